//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // fetch addressing
  localparam logic [63:0] RESET_PC = 64'h0000_0000_8000_0000; // first fetch after reset
  localparam int INST_BYTES = 4;                             // sequential step
  localparam int LINES      = 64;                            // direct-mapped lines
  localparam int INDEX_W    = $clog2(LINES);                 // 6
  localparam int LINE_BYTES = 8;                             // two insts per line
  localparam int OFFSET_W   = $clog2(LINE_BYTES);            // 3
  localparam int TAG_W      = 64 - INDEX_W - OFFSET_W;       // 55

  localparam logic [31:0] NOP_INST   = 32'h0000_0013; // addi x0,x0,0, used on bus error
  localparam logic [7:0]  WB_SEL_ALL = 8'hff;         // full 64-bit read

  typedef logic [63:0]      pc_t;    // byte address
  typedef logic [31:0]      inst_t;  // one instruction
  typedef logic [63:0]      line_t;  // cache line == bus width
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  // pc_gen -> icache
  typedef struct packed {
    pc_t pc;
  } fetch_req_t;

  // icache -> decode
  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_rsp_t;

  // icache -> refill master, line aligned
  typedef struct packed {
    pc_t addr;
  } refill_req_t;

  // wishbone classic, read only
  typedef struct packed {
    logic       cyc;
    logic       stb;
    pc_t        adr;
    logic [7:0] sel;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    line_t dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} icache_state_e;

endpackage

//--- verilog/pc_gen.sv
`timescale 1ns/10ps

module pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_i,    // from a later stage
  input  fetch_pkg::pc_t         redirect_pc_i,
  output fetch_pkg::fetch_req_t  req_o,
  output logic                   req_valid_o,
  input  logic                   req_ready_i
);

  fetch_pkg::pc_t pc_q;  // address currently offered
  logic           run_q; // set once out of reset
  logic           step;

  assign step = req_valid_o && req_ready_i; // request taken by icache

  // pc register
  // redirect beats the sequential step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (step) begin
      pc_q <= pc_q + fetch_pkg::pc_t'(fetch_pkg::INST_BYTES); // next sequential inst
    end
  end

  // always requesting once running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  assign req_valid_o = run_q;
  assign req_o.pc    = pc_q; // held until step

endmodule

//--- verilog/icache.sv
`timescale 1ns/10ps

module icache (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fetch_pkg::fetch_req_t   req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    redirect_i,
  input  logic                    invalidate_i,
  output fetch_pkg::fetch_rsp_t   rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output fetch_pkg::refill_req_t  refill_o,
  output logic                    refill_valid_o,
  input  logic                    refill_done_i,
  input  fetch_pkg::line_t        refill_data_i,
  input  logic                    refill_err_i
);

  // storage
  fetch_pkg::line_t        data_mem [fetch_pkg::LINES];
  fetch_pkg::tag_t         tag_mem  [fetch_pkg::LINES];
  logic [fetch_pkg::LINES-1:0] valid_q;

  fetch_pkg::icache_state_e state_q, state_d;
  fetch_pkg::fetch_req_t    req_q;     // request under lookup
  fetch_pkg::fetch_rsp_t    rsp_q;     // held response
  logic                     rsp_valid_q;
  logic                     kill_q;    // refill result no longer wanted
  logic                     err_q;     // last refill ended with err

  fetch_pkg::tag_t   tag;
  fetch_pkg::index_t idx;
  fetch_pkg::line_t  line;
  fetch_pkg::inst_t  inst_sel;
  logic              hit;
  logic              out_free;
  logic              deliver;
  logic              accept;

  // address split of the looked-up pc
  assign tag  = req_q.pc[63 -: fetch_pkg::TAG_W];
  assign idx  = req_q.pc[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
  assign line = data_mem[idx];

  assign hit      = (state_q == fetch_pkg::LOOKUP) && valid_q[idx] && (tag_mem[idx] == tag);
  assign out_free = !rsp_valid_q || rsp_ready_i; // slot empty or draining now

  // hit in LOOKUP, or line back from refill
  assign deliver = !redirect_i && out_free &&
                   (hit || (state_q == fetch_pkg::RESPOND));

  // new request only when the lookup slot frees up
  assign req_ready_o = !redirect_i && ((state_q == fetch_pkg::IDLE) || deliver);
  assign accept      = req_valid_i && req_ready_o;

  // pc bit 2 picks the half, err gives nop
  assign inst_sel = (state_q == fetch_pkg::RESPOND && err_q) ? fetch_pkg::NOP_INST :
                    (req_q.pc[2] ? line[63:32] : line[31:0]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::IDLE: begin
        if (accept) state_d = fetch_pkg::LOOKUP;
      end
      fetch_pkg::LOOKUP: begin
        if (redirect_i) begin
          state_d = fetch_pkg::IDLE;      // drop the lookup
        end else if (!hit) begin
          state_d = fetch_pkg::REFILL;    // miss
        end else if (deliver) begin
          state_d = accept ? fetch_pkg::LOOKUP : fetch_pkg::IDLE;
        end
      end
      fetch_pkg::REFILL: begin
        if (refill_done_i) begin
          state_d = (kill_q || redirect_i) ? fetch_pkg::IDLE : fetch_pkg::RESPOND;
        end
      end
      fetch_pkg::RESPOND: begin
        if (redirect_i) begin
          state_d = fetch_pkg::IDLE;
        end else if (deliver) begin
          state_d = accept ? fetch_pkg::LOOKUP : fetch_pkg::IDLE;
        end
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  // control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= fetch_pkg::IDLE;
      rsp_valid_q <= 1'b0;
      kill_q      <= 1'b0;
      err_q       <= 1'b0;
      valid_q     <= '0;
    end else begin
      state_q <= state_d;
      if (redirect_i) begin
        rsp_valid_q <= 1'b0;               // stale response thrown away
      end else if (deliver) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      // remember a redirect seen while the bus is busy
      kill_q <= (state_q == fetch_pkg::REFILL) && !refill_done_i && (kill_q || redirect_i);
      if (refill_done_i && state_q == fetch_pkg::REFILL) err_q <= refill_err_i;
      if (invalidate_i) valid_q <= '0;     // flush all lines
      // fill after flush so a same-cycle refill lands
      if (refill_done_i && state_q == fetch_pkg::REFILL && !refill_err_i) begin
        valid_q[idx] <= 1'b1;
      end
    end
  end

  // payload: lookup register, response, line arrays
  always_ff @(posedge clk) begin
    if (accept) req_q <= req_i;
    if (deliver) begin
      rsp_q.pc   <= req_q.pc;
      rsp_q.inst <= inst_sel;
    end
    if (refill_done_i && state_q == fetch_pkg::REFILL && !refill_err_i) begin
      data_mem[idx] <= refill_data_i; // killed refills still fill
      tag_mem[idx]  <= tag;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  assign refill_o.addr  = {req_q.pc[63:fetch_pkg::OFFSET_W], {fetch_pkg::OFFSET_W{1'b0}}};
  assign refill_valid_o = (state_q == fetch_pkg::REFILL);

  // consumer sees a steady response while stalled
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o));

  // request held up until the master reports done
  a_refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
    refill_valid_o && !refill_done_i |=> refill_valid_o && $stable(refill_o));

endmodule

//--- verilog/wb_refill_master.sv
`timescale 1ns/10ps

module wb_refill_master (
  input  logic                    clk,
  input  logic                    rst_n,
  input  fetch_pkg::refill_req_t  refill_i,
  input  logic                    refill_valid_i,
  output logic                    refill_done_o,
  output fetch_pkg::line_t        refill_data_o,
  output logic                    refill_err_o,
  output fetch_pkg::wb_m2s_t      wb_o,
  input  fetch_pkg::wb_s2m_t      wb_i
);

  typedef enum logic {M_IDLE, M_BUSY} mst_state_e;

  mst_state_e       state_q;
  fetch_pkg::pc_t   adr_q;   // latched line address
  fetch_pkg::line_t data_q;  // captured read data
  logic             err_q;
  logic             done_q;  // one cycle pulse
  logic             start;
  logic             term;

  // icache still shows valid in the done cycle, so skip that one
  assign start = (state_q == M_IDLE) && refill_valid_i && !done_q;
  assign term  = (state_q == M_BUSY) && (wb_i.ack || wb_i.err); // cycle ends

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= term;
      if (start) begin
        state_q <= M_BUSY;  // cyc/stb up next cycle
      end else if (term) begin
        state_q <= M_IDLE;  // drop after ack/err
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) adr_q <= refill_i.addr;
    if (term) begin
      data_q <= wb_i.dat;
      err_q  <= wb_i.err;
    end
  end

  // classic read, no write side
  assign wb_o.cyc = (state_q == M_BUSY);
  assign wb_o.stb = (state_q == M_BUSY);
  assign wb_o.adr = adr_q;
  assign wb_o.sel = fetch_pkg::WB_SEL_ALL;

  assign refill_done_o = done_q;
  assign refill_data_o = data_q;
  assign refill_err_o  = err_q;

  // address frozen until the slave terminates
  a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.stb && !wb_i.ack && !wb_i.err |=> $stable(wb_o.adr));

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_i,
  input  fetch_pkg::pc_t         redirect_pc_i,
  input  logic                   invalidate_i,
  output fetch_pkg::fetch_rsp_t  inst_o,
  output logic                   inst_valid_o,
  input  logic                   inst_ready_i,
  output fetch_pkg::wb_m2s_t     wb_o,
  input  fetch_pkg::wb_s2m_t     wb_i
);

  // pc_gen <-> icache
  fetch_pkg::fetch_req_t  req;
  logic                   req_valid;
  logic                   req_ready;

  // icache <-> refill master
  fetch_pkg::refill_req_t refill;
  logic                   refill_valid;
  logic                   refill_done;
  fetch_pkg::line_t       refill_data;
  logic                   refill_err;

  pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .req_o         (req),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready)
  );

  icache i_icache (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .redirect_i     (redirect_i),   // also drops in-flight fetch
    .invalidate_i   (invalidate_i),
    .rsp_o          (inst_o),
    .rsp_valid_o    (inst_valid_o),
    .rsp_ready_i    (inst_ready_i),
    .refill_o       (refill),
    .refill_valid_o (refill_valid),
    .refill_done_i  (refill_done),
    .refill_data_i  (refill_data),
    .refill_err_i   (refill_err)
  );

  wb_refill_master i_wb_refill_master (
    .clk            (clk),
    .rst_n          (rst_n),
    .refill_i       (refill),
    .refill_valid_i (refill_valid),
    .refill_done_o  (refill_done),
    .refill_data_o  (refill_data),
    .refill_err_o   (refill_err),
    .wb_o           (wb_o),
    .wb_i           (wb_i)
  );

endmodule

//--- dv/wb_mem_model.sv
`timescale 1ns/10ps

module wb_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::wb_m2s_t wb_i,      // from the fetch master
  output fetch_pkg::wb_s2m_t wb_o,
  output int                 cycles_o   // bus cycles seen so far
);

  fetch_pkg::wb_s2m_t rsp_q;
  logic               busy_q;    // cycle seen, counting waits
  logic [1:0]         wait_q;    // wait states left
  int                 cycles_q;

  // program content, word at byte address p
  function automatic logic [31:0] inst_at(input logic [63:0] p);
    return p[31:0] ^ 32'h5a5a_0000;
  endfunction

  // line addresses that answer with err
  function automatic logic in_err_window(input logic [63:0] a);
    return (a >= 64'h9000_0000) && (a <= 64'h9000_00ff);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q    <= '0;
      busy_q   <= 1'b0;
      wait_q   <= 2'd0;
      cycles_q <= 0;
    end else begin
      rsp_q.ack <= 1'b0; // ack/err are single cycle
      rsp_q.err <= 1'b0;
      // master holds cyc/stb until it sees the termination
      if (wb_i.cyc && wb_i.stb && !rsp_q.ack && !rsp_q.err) begin
        if (!busy_q) begin
          busy_q   <= 1'b1;
          wait_q   <= 2'($urandom_range(3, 0)); // 0..3 extra cycles
          cycles_q <= cycles_q + 1;
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q    <= 1'b0;
          rsp_q.dat <= {inst_at(wb_i.adr + 64'd4), inst_at(wb_i.adr)}; // high word = A+4
          if (in_err_window(wb_i.adr)) begin
            rsp_q.err <= 1'b1;
          end else begin
            rsp_q.ack <= 1'b1;
          end
        end
      end
    end
  end

  assign wb_o     = rsp_q;
  assign cycles_o = cycles_q;

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

  logic                  clk;
  logic                  rst_n;
  logic                  redirect_i;
  fetch_pkg::pc_t        redirect_pc_i;
  logic                  invalidate_i;
  logic                  inst_ready_i;
  fetch_pkg::fetch_rsp_t inst_o;
  logic                  inst_valid_o;
  fetch_pkg::wb_m2s_t    wb_m2s;          // dut -> memory
  fetch_pkg::wb_s2m_t    wb_s2m;          // memory -> dut
  int                    bus_cycles;

  fetch_pkg::fetch_rsp_t got_q[$];        // accepted responses, oldest first
  int                    cnt_q[$];        // bus cycle count at each accept
  fetch_pkg::fetch_rsp_t held_q;          // response seen at the last edge
  logic                  stall_q = 1'b0;  // last edge was a stall
  int                    errors = 0;
  int                    cycle_cnt = 0;

  fetch_top i_fetch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .invalidate_i  (invalidate_i),
    .inst_o        (inst_o),
    .inst_valid_o  (inst_valid_o),
    .inst_ready_i  (inst_ready_i),
    .wb_o          (wb_m2s),
    .wb_i          (wb_s2m)
  );

  wb_mem_model i_wb_mem_model (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_i     (wb_m2s),
    .wb_o     (wb_s2m),
    .cycles_o (bus_cycles)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk; // 40 ns period

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // program rule, nop inside the err window
  function automatic logic [31:0] expected_inst(input logic [63:0] pc);
    if (pc >= 64'h9000_0000 && pc <= 64'h9000_00ff) return 32'h0000_0013;
    return pc[31:0] ^ 32'h5a5a_0000;
  endfunction

  // handshake monitor, sampled at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (stall_q) begin                     // response must survive a stall
        compare("inst_valid_o", 64'd1, {63'd0, inst_valid_o});
        compare("inst_o.pc held", held_q.pc, inst_o.pc);
        compare("inst_o.inst held", {32'd0, held_q.inst}, {32'd0, inst_o.inst});
      end
      if (inst_valid_o && inst_ready_i) begin
        got_q.push_back(inst_o);
        cnt_q.push_back(bus_cycles);
      end
      stall_q <= inst_valid_o && !inst_ready_i && !redirect_i; // redirect may drop it
      held_q  <= inst_o;
    end
  end

  // read-only classic cycle, full width, line aligned
  always @(posedge clk) begin
    if (rst_n) begin
      compare("wb_o.stb", {63'd0, wb_m2s.cyc}, {63'd0, wb_m2s.stb});
      if (wb_m2s.cyc) begin
        compare("wb_o.sel", 64'hff, {56'd0, wb_m2s.sel});
        compare("wb_o.adr[2:0]", 64'd0, {61'd0, wb_m2s.adr[2:0]});
      end
    end
  end

  // ~180 responses, worst miss about 10 cycles per line plus stalls, so 4000 leaves margin
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 4000) begin
      $display("timeout after %0d cycles, fetch did not deliver the expected responses",
               cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic wait_responses(input int n);
    while (got_q.size() < n) @(negedge clk);
  endtask

  // pops n responses, expects pcs start, start+4, ...
  task automatic check_stream(input fetch_pkg::pc_t start, input int n, output int bus_delta);
    fetch_pkg::fetch_rsp_t rsp;
    fetch_pkg::pc_t        pc;
    int                    first_cnt;
    int                    cnt;
    int                    i;
    wait_responses(n);
    first_cnt = cnt_q[0];
    cnt       = first_cnt;
    for (i = 0; i < n; i++) begin
      rsp = got_q.pop_front();
      cnt = cnt_q.pop_front();
      pc  = start + fetch_pkg::pc_t'(4 * i);
      compare("inst_o.pc", pc, rsp.pc);
      compare("inst_o.inst", {32'd0, expected_inst(pc)}, {32'd0, rsp.inst});
    end
    bus_delta = cnt - first_cnt; // refills after the first response
  endtask

  // one cycle redirect pulse, then forget the old stream
  task automatic redirect_to(input fetch_pkg::pc_t pc);
    @(negedge clk);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    @(negedge clk);
    redirect_i = 1'b0;
    got_q.delete();   // everything up to the redirect edge is old
    cnt_q.delete();
  endtask

  task automatic sequential_fetch();
    int delta;
    check_stream(64'h0000_0000_8000_0000, 32, delta); // cold cache from reset vector
    compare("bus cycles", 64'd15, 64'(delta));         // 16 lines
  endtask

  task automatic hit_refetch();
    int base;
    int delta;
    redirect_to(64'h0000_0000_8000_0000);
    while (wb_m2s.cyc) @(negedge clk);                // dropped refill still runs out
    base = bus_cycles;
    wait_responses(1);
    compare("bus cycles", 64'(base), 64'(cnt_q[0]));  // first line hits too
    check_stream(64'h0000_0000_8000_0000, 32, delta);
    compare("bus cycles", 64'd0, 64'(delta));          // all hits
  endtask

  task automatic redirect_in_flight();
    int delta;
    redirect_to(64'h0000_0000_8000_0200);
    wait_responses(2);
    while (!wb_m2s.cyc) @(negedge clk);  // refill on the bus
    redirect_to(64'h0000_0000_8000_0600); // same index, other tag
    check_stream(64'h0000_0000_8000_0600, 8, delta);
  endtask

  task automatic backpressure_stall();
    int stretch;
    int delta;
    redirect_to(64'h0000_0000_8000_1000);
    stretch = 0;
    while (got_q.size() < 40) begin
      @(negedge clk);
      if (stretch == 0) begin
        inst_ready_i = ~inst_ready_i;
        stretch      = $urandom_range(6, 1); // random stretch length
      end else begin
        stretch--;
      end
    end
    inst_ready_i = 1'b1;
    check_stream(64'h0000_0000_8000_1000, 40, delta);
  endtask

  task automatic invalidate_refetch();
    int delta;
    redirect_to(64'h0000_0000_8000_0000);             // lines 0..15 resident again
    check_stream(64'h0000_0000_8000_0000, 32, delta);
    @(negedge clk);
    invalidate_i = 1'b1;
    @(negedge clk);
    invalidate_i = 1'b0;
    redirect_to(64'h0000_0000_8000_0000);
    check_stream(64'h0000_0000_8000_0000, 32, delta);
    compare("bus cycles", 64'd15, 64'(delta)); // one per line again
  endtask

  task automatic bus_error_nop();
    int delta;
    redirect_to(64'h0000_0000_9000_00f8); // last err line, then normal memory
    check_stream(64'h0000_0000_9000_00f8, 6, delta);
  endtask

  initial begin
    void'($urandom(32'h0318_42fd));
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    invalidate_i  = 1'b0;
    inst_ready_i  = 1'b1;
    repeat (5) @(negedge clk);
    compare("inst_valid_o", 64'd0, {63'd0, inst_valid_o}); // quiet under reset
    compare("wb_o.cyc", 64'd0, {63'd0, wb_m2s.cyc});
    compare("wb_o.stb", 64'd0, {63'd0, wb_m2s.stb});
    rst_n = 1'b1;

    sequential_fetch();
    hit_refetch();
    redirect_in_flight();
    backpressure_stall();
    invalidate_refetch();
    bus_error_nop();

    $display("run done: %0d errors, %0d bus cycles, %0d clock cycles",
             errors, bus_cycles, cycle_cnt);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/icache.sv
verilog/wb_refill_master.sv
verilog/fetch_top.sv
dv/wb_mem_model.sv
dv/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build fetch_tb with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

build_dir=build
log="$build_dir/sim.log"

mkdir -p "$build_dir" || exit 1

verilator --binary --timing --assert -f project.f --top-module fetch_tb \
  -Mdir "$build_dir/obj" -o fetch_sim \
  || { echo "verilator build failed"; exit 1; }

"$build_dir/obj/fetch_sim" > "$log" 2>&1 \
  || { cat "$log"; echo "simulation exited with an error"; exit 1; }

cat "$log"
grep -q '>>> FAIL' "$log" && { echo "testbench reported failure"; exit 1; }
grep -q '>>> PASS' "$log" || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"
